// ==== cpu_core.f ====
source/cpu_pkg.sv
source/alu.sv
source/imm_gen.sv
source/decoder.sv
source/reg_file.sv
source/word_ram.sv
source/stage_reg.sv
source/cpu_core.sv
tests/clock_gen.sv
tests/cpu_core_chk.sv
tests/cpu_core_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -eo pipefail

cd "$(dirname "$0")"

verilator --binary --assert -f cpu_core.f --top-module cpu_core_tb -Mdir obj_dir -o cpu_core_sim

./obj_dir/cpu_core_sim 2>&1 | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::word_t   a,
    input  cpu_pkg::word_t   b,
    input  cpu_pkg::alu_op_t op,
    output cpu_pkg::word_t   y
);

    logic [4:0] shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (op)
            cpu_pkg::ALU_ADD:    y = a + b;
            cpu_pkg::ALU_SUB:    y = a - b;
            cpu_pkg::ALU_SLL:    y = a << shamt;
            cpu_pkg::ALU_SLT:    y = {31'd0, $signed(a) < $signed(b)};
            cpu_pkg::ALU_SLTU:   y = {31'd0, a < b};
            cpu_pkg::ALU_XOR:    y = a ^ b;
            cpu_pkg::ALU_SRL:    y = a >> shamt;
            // arithmetic shift keeps the sign of a
            cpu_pkg::ALU_SRA:    y = cpu_pkg::word_t'($signed(a) >>> shamt);
            cpu_pkg::ALU_OR:     y = a | b;
            cpu_pkg::ALU_AND:    y = a & b;
            // lui passes the U immediate straight through
            cpu_pkg::ALU_COPY_B: y = b;
            default:             y = '0;
        endcase
    end

endmodule

// ==== source/cpu_core.sv ====
`timescale 1ns/1ps

module cpu_core #(
    parameter cpu_pkg::word_t RESET_PC   = '0,
    parameter int             IMEM_DEPTH = 1024,
    parameter int             DMEM_DEPTH = 1024
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           prog_we,
    input  logic [9:0]     prog_addr,
    input  cpu_pkg::word_t prog_data,
    output logic           tohost_valid,
    output cpu_pkg::word_t tohost_data
);

    localparam int IMEM_AW = $clog2(IMEM_DEPTH);
    localparam int DMEM_AW = $clog2(DMEM_DEPTH);

    cpu_pkg::word_t       pc, pc_next, pc_plus_4, target;
    cpu_pkg::word_t       imem_rdata, inst, rd1, rd2, imm_d;
    cpu_pkg::word_t       a_ex, b_ex, alu_a, alu_b, alu_y;
    cpu_pkg::word_t       dmem_rdata, wb_data;
    cpu_pkg::ctrl_t       ctrl_d;
    cpu_pkg::ex_payload_t ex_d, ex;
    cpu_pkg::wb_payload_t wb_d, wb;
    logic                 fwd_a_dec, fwd_b_dec, fwd_a_ex, fwd_b_ex;
    logic                 redirect, flush;

    // fetch: imem is addressed with the next pc so data lines up with pc
    assign pc_plus_4 = pc + 32'd4;
    assign target = {alu_y[31:1], 1'b0};
    assign pc_next = rst ? RESET_PC : (redirect ? target : pc_plus_4);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    word_ram #(.DEPTH(IMEM_DEPTH)) imem (
        .clk(clk), .we(prog_we),
        .waddr(prog_addr[IMEM_AW-1:0]), .raddr(pc_next[IMEM_AW+1:2]),
        .wdata(prog_data), .rdata(imem_rdata)
    );

    assign inst = flush ? cpu_pkg::NOP_WORD : imem_rdata;

    // decode
    decoder dec (
        .inst(inst), .ex(ex), .wb(wb), .a_ex(a_ex), .b_ex(b_ex), .ctrl(ctrl_d),
        .fwd_a_dec(fwd_a_dec), .fwd_b_dec(fwd_b_dec),
        .fwd_a_ex(fwd_a_ex), .fwd_b_ex(fwd_b_ex),
        .redirect(redirect), .flush(flush)
    );

    reg_file rf (
        .clk(clk), .ra1(inst[19:15]), .ra2(inst[24:20]), .wa(wb.rd),
        .we(wb.reg_we), .wd(wb_data), .rd1(rd1), .rd2(rd2)
    );

    imm_gen imm (.inst(inst), .sel(ctrl_d.imm_sel), .imm(imm_d));

    always_comb begin
        ex_d.ctrl = ctrl_d;
        ex_d.pc = pc;
        ex_d.pc_plus_4 = pc_plus_4;
        // writeback result is not in the register file until the edge
        ex_d.rs1_data = fwd_a_dec ? wb_data : rd1;
        ex_d.rs2_data = fwd_b_dec ? wb_data : rd2;
        ex_d.imm = imm_d;
        ex_d.rd = inst[11:7];
        ex_d.rs1 = inst[19:15];
        ex_d.rs2 = inst[24:20];
        ex_d.zimm = inst[19:15];
    end

    stage_reg #(.payload_t(cpu_pkg::ex_payload_t)) ex_stage (
        .clk(clk), .rst(rst), .d(ex_d), .q(ex)
    );

    // execute
    assign a_ex = fwd_a_ex ? wb_data : ex.rs1_data;
    assign b_ex = fwd_b_ex ? wb_data : ex.rs2_data;
    assign alu_a = ex.ctrl.a_pc ? ex.pc : a_ex;
    assign alu_b = ex.ctrl.b_imm ? ex.imm : b_ex;

    alu alu0 (.a(alu_a), .b(alu_b), .op(ex.ctrl.alu_op), .y(alu_y));

    // read data lands in writeback as the third stage register
    word_ram #(.DEPTH(DMEM_DEPTH)) dmem (
        .clk(clk), .we(ex.ctrl.mem_we),
        .waddr(alu_y[DMEM_AW+1:2]), .raddr(alu_y[DMEM_AW+1:2]),
        .wdata(b_ex), .rdata(dmem_rdata)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            tohost_valid <= 1'b0;
        end else begin
            tohost_valid <= ex.ctrl.csr_we;
        end
    end

    always_ff @(posedge clk) begin
        if (ex.ctrl.csr_we) begin
            tohost_data <= ex.ctrl.csr_imm ? {27'd0, ex.zimm} : a_ex;
        end
    end

    always_comb begin
        wb_d.reg_we = ex.ctrl.reg_we;
        wb_d.wb_sel = ex.ctrl.wb_sel;
        wb_d.rd = ex.rd;
        wb_d.alu_y = alu_y;
        wb_d.pc_plus_4 = ex.pc_plus_4;
    end

    stage_reg #(.payload_t(cpu_pkg::wb_payload_t)) wb_stage (
        .clk(clk), .rst(rst), .d(wb_d), .q(wb)
    );

    // writeback
    always_comb begin
        case (wb.wb_sel)
            cpu_pkg::WB_MEM: wb_data = dmem_rdata;
            cpu_pkg::WB_PC4: wb_data = wb.pc_plus_4;
            default:         wb_data = wb.alu_y;
        endcase
    end

endmodule

// ==== source/cpu_pkg.sv ====
package cpu_pkg;

    typedef logic [31:0] word_t;

    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_COPY_B
    } alu_op_t;

    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_sel_t;

    typedef enum logic [1:0] {WB_MEM, WB_ALU, WB_PC4} wb_sel_t;

    // all-zero encoding must stay a bubble
    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE} br_kind_t;

    typedef struct packed {
        alu_op_t  alu_op;
        imm_sel_t imm_sel;
        logic     a_pc;
        logic     b_imm;
        logic     br_un;
        br_kind_t br_kind;
        logic     jump;
        logic     mem_we;
        logic     reg_we;
        wb_sel_t  wb_sel;
        logic     csr_we;
        logic     csr_imm;
    } ctrl_t;

    typedef struct packed {
        ctrl_t      ctrl;
        word_t      pc;
        word_t      pc_plus_4;
        word_t      rs1_data;
        word_t      rs2_data;
        word_t      imm;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] zimm;
    } ex_payload_t;

    typedef struct packed {
        logic       reg_we;
        wb_sel_t    wb_sel;
        logic [4:0] rd;
        word_t      alu_y;
        word_t      pc_plus_4;
    } wb_payload_t;

    localparam logic [11:0] TOHOST_CSR = 12'h51e;
    localparam word_t       NOP_WORD   = 32'h0000_0013;

endpackage

// ==== source/decoder.sv ====
`timescale 1ns/1ps

module decoder (
    input  cpu_pkg::word_t       inst,
    input  cpu_pkg::ex_payload_t ex,
    input  cpu_pkg::wb_payload_t wb,
    input  cpu_pkg::word_t       a_ex,
    input  cpu_pkg::word_t       b_ex,
    output cpu_pkg::ctrl_t       ctrl,
    output logic                 fwd_a_dec,
    output logic                 fwd_b_dec,
    output logic                 fwd_a_ex,
    output logic                 fwd_b_ex,
    output logic                 redirect,
    output logic                 flush
);

    logic [2:0] funct3;
    logic       alt;
    logic       wb_fwd;
    logic       br_eq;
    logic       br_lt;
    logic       taken;

    function automatic cpu_pkg::alu_op_t alu_sel(input logic [2:0] f3, input logic sub_sra);
        case (f3)
            3'b000:  alu_sel = sub_sra ? cpu_pkg::ALU_SUB : cpu_pkg::ALU_ADD;
            3'b001:  alu_sel = cpu_pkg::ALU_SLL;
            3'b010:  alu_sel = cpu_pkg::ALU_SLT;
            3'b011:  alu_sel = cpu_pkg::ALU_SLTU;
            3'b100:  alu_sel = cpu_pkg::ALU_XOR;
            3'b101:  alu_sel = sub_sra ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
            3'b110:  alu_sel = cpu_pkg::ALU_OR;
            default: alu_sel = cpu_pkg::ALU_AND;
        endcase
    endfunction

    assign funct3 = inst[14:12];
    assign alt = inst[30];

    always_comb begin
        ctrl = '0;
        case (inst[6:0])
            cpu_pkg::OP_LUI: begin
                ctrl.imm_sel = cpu_pkg::IMM_U;
                ctrl.b_imm = 1'b1;
                ctrl.alu_op = cpu_pkg::ALU_COPY_B;
                ctrl.reg_we = 1'b1;
                ctrl.wb_sel = cpu_pkg::WB_ALU;
            end
            cpu_pkg::OP_AUIPC: begin
                ctrl.imm_sel = cpu_pkg::IMM_U;
                ctrl.a_pc = 1'b1;
                ctrl.b_imm = 1'b1;
                ctrl.reg_we = 1'b1;
                ctrl.wb_sel = cpu_pkg::WB_ALU;
            end
            cpu_pkg::OP_JAL, cpu_pkg::OP_JALR: begin
                // target comes from the adder, rd gets the link address
                ctrl.imm_sel = inst[3] ? cpu_pkg::IMM_J : cpu_pkg::IMM_I;
                ctrl.a_pc = inst[3];
                ctrl.b_imm = 1'b1;
                ctrl.jump = 1'b1;
                ctrl.reg_we = 1'b1;
                ctrl.wb_sel = cpu_pkg::WB_PC4;
            end
            cpu_pkg::OP_BRANCH: begin
                ctrl.imm_sel = cpu_pkg::IMM_B;
                ctrl.a_pc = 1'b1;
                ctrl.b_imm = 1'b1;
                ctrl.br_un = funct3[1];
                case (funct3)
                    3'b000:         ctrl.br_kind = cpu_pkg::BR_EQ;
                    3'b001:         ctrl.br_kind = cpu_pkg::BR_NE;
                    3'b100, 3'b110: ctrl.br_kind = cpu_pkg::BR_LT;
                    3'b101, 3'b111: ctrl.br_kind = cpu_pkg::BR_GE;
                    default:        ctrl.br_kind = cpu_pkg::BR_NONE;
                endcase
            end
            cpu_pkg::OP_LOAD: begin
                ctrl.b_imm = 1'b1;
                ctrl.reg_we = 1'b1;
                ctrl.wb_sel = cpu_pkg::WB_MEM;
            end
            cpu_pkg::OP_STORE: begin
                ctrl.imm_sel = cpu_pkg::IMM_S;
                ctrl.b_imm = 1'b1;
                ctrl.mem_we = 1'b1;
            end
            cpu_pkg::OP_IMM: begin
                ctrl.b_imm = 1'b1;
                ctrl.alu_op = alu_sel(funct3, alt && funct3 == 3'b101);
                ctrl.reg_we = 1'b1;
                ctrl.wb_sel = cpu_pkg::WB_ALU;
            end
            cpu_pkg::OP_REG: begin
                ctrl.alu_op = alu_sel(funct3, alt);
                ctrl.reg_we = 1'b1;
                ctrl.wb_sel = cpu_pkg::WB_ALU;
            end
            cpu_pkg::OP_SYSTEM: begin
                // only csrrw / csrrwi to tohost, anything else is a nop
                ctrl.csr_we = (inst[31:20] == cpu_pkg::TOHOST_CSR) && (funct3[1:0] == 2'b01);
                ctrl.csr_imm = funct3[2];
            end
            default: ctrl = '0;
        endcase
    end

    assign wb_fwd = wb.reg_we && (wb.rd != 5'd0);
    assign fwd_a_dec = wb_fwd && (wb.rd == inst[19:15]);
    assign fwd_b_dec = wb_fwd && (wb.rd == inst[24:20]);
    assign fwd_a_ex = wb_fwd && (wb.rd == ex.rs1);
    assign fwd_b_ex = wb_fwd && (wb.rd == ex.rs2);

    // branch compare on the forwarded execute operands
    always_comb begin
        br_eq = (a_ex == b_ex);
        br_lt = ex.ctrl.br_un ? (a_ex < b_ex) : ($signed(a_ex) < $signed(b_ex));
        case (ex.ctrl.br_kind)
            cpu_pkg::BR_EQ: taken = br_eq;
            cpu_pkg::BR_NE: taken = !br_eq;
            cpu_pkg::BR_LT: taken = br_lt;
            cpu_pkg::BR_GE: taken = !br_lt;
            default:        taken = 1'b0;
        endcase
    end

    assign redirect = ex.ctrl.jump || taken;
    // the one instruction fetched behind a redirect is dropped
    assign flush = redirect;

endmodule

// ==== source/imm_gen.sv ====
`timescale 1ns/1ps

module imm_gen (
    input  cpu_pkg::word_t    inst,
    input  cpu_pkg::imm_sel_t sel,
    output cpu_pkg::word_t    imm
);

    logic sign;

    assign sign = inst[31];

    always_comb begin
        case (sel)
            cpu_pkg::IMM_I: imm = {{20{sign}}, inst[31:20]};
            cpu_pkg::IMM_S: imm = {{20{sign}}, inst[31:25], inst[11:7]};
            // branch offsets are in halfwords, bit 0 always clear
            cpu_pkg::IMM_B: imm = {{19{sign}}, sign, inst[7], inst[30:25], inst[11:8], 1'b0};
            cpu_pkg::IMM_U: imm = {inst[31:12], 12'd0};
            cpu_pkg::IMM_J: begin
                imm = {{11{sign}}, sign, inst[19:12], inst[20], inst[30:21], 1'b0};
            end
            default:        imm = '0;
        endcase
    end

endmodule

// ==== source/reg_file.sv ====
`timescale 1ns/1ps

module reg_file (
    input  logic           clk,
    input  logic [4:0]     ra1,
    input  logic [4:0]     ra2,
    input  logic [4:0]     wa,
    input  logic           we,
    input  cpu_pkg::word_t wd,
    output cpu_pkg::word_t rd1,
    output cpu_pkg::word_t rd2
);

    cpu_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (we && wa != 5'd0) begin
            regs[wa] <= wd;
        end
    end

    // x0 never holds anything but zero
    assign rd1 = (ra1 == 5'd0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == 5'd0) ? '0 : regs[ra2];

endmodule

// ==== source/stage_reg.sv ====
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t d,
    output payload_t q
);

    // cleared payload acts as a bubble
    always_ff @(posedge clk) begin
        if (rst) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

// ==== source/word_ram.sv ====
`timescale 1ns/1ps

module word_ram #(
    parameter int DEPTH = 1024
) (
    input  logic                     clk,
    input  logic                     we,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    input  cpu_pkg::word_t           wdata,
    output cpu_pkg::word_t           rdata
);

    cpu_pkg::word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        // write-first when both ports hit the same word
        rdata <= (we && waddr == raddr) ? wdata : mem[raddr];
    end

endmodule

// ==== tests/clock_gen.sv ====
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 8,
    parameter int HOLD_LIMIT   = 4096
) (
    input  logic hold,
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
    end

    always #(PERIOD_NS / 2) clk = ~clk;

    // reset covers program loading, then RESET_CYCLES more edges
    initial begin
        int n;
        n = 0;
        rst = 1'b1;
        @(posedge clk);
        while (hold && n < HOLD_LIMIT) begin
            @(posedge clk);
            n++;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== tests/cpu_core_chk.sv ====
`timescale 1ns/1ps

module cpu_core_chk (
    input logic           clk,
    input logic           rst,
    input logic           tohost_valid,
    input cpu_pkg::word_t pc,
    input logic [4:0]     rs1_ex,
    input logic [4:0]     rs2_ex,
    input cpu_pkg::word_t a_ex,
    input cpu_pkg::word_t b_ex
);

    // nothing reaches execute until two edges after reset
    no_strobe_in_reset: assert property (
        @(posedge clk) $past(rst, 2) |-> !tohost_valid
    ) else $error("tohost strobe during reset or right after it");

    pc_aligned: assert property (@(posedge clk) !rst |-> pc[1:0] == 2'b00)
        else $error("pc is not word aligned");

    // x0 on either execute operand, after forwarding
    x0_zero_a: assert property (@(posedge clk) !rst && rs1_ex == 5'd0 |-> a_ex == '0)
        else $error("x0 operand a in execute is not zero");

    x0_zero_b: assert property (@(posedge clk) !rst && rs2_ex == 5'd0 |-> b_ex == '0)
        else $error("x0 operand b in execute is not zero");

endmodule

// ==== tests/cpu_core_patterns.txt ====
// program word count, program words in hex from address 0 upward,
// then expected tohost write count and the expected tohost values in order
0000004A
// alu, shifts, slt/sltu, lui, auipc
00500093 FFD00113 002081B3 51E19073 40208233 51E21073 0020C2B3 51E29073
0020F333 51E31073 40115393 51E39073 01C15413 51E41073 00309493 51E49073
00112533 001135B3 51E51073 51E59073 12345637 67860613 51E61073 00001697
51E69073
// forwarding back to back, then spaced by nops
00A00713 00170713 00170713 00170713 51E71073
00A00793 00178793 00000013 00178793 00000013 00000013 00178793 51E79073
// store, load, load followed by use
04000813 00C82023 00582223 00082883 51E89073 00482903 FFF94913 51E91073
// branches, taken ones skip the addi behind them
00000A13 00108463 001A0A13 00109463 002A0A13 00114463 004A0A13 00115463
008A0A13 00116463 010A0A13 00117463 020A0A13 00209463 040A0A13 00208463
080A0A13 51EA1073
// jal, jalr, csrwi, final self loop
00800AEF 51EFD073 51EA9073 00000B17 010B0BE7 51EFD073 51EF5073 51EB9073
51EAD073 0000006F
// expected tohost values
00000013
00000002 00000008 FFFFFFF8 00000005 FFFFFFFE 0000000F 00000028 00000001
00000000 12345678 0000105C 0000000D 0000000D 12345678 00000007 0000009A
00000104 00000114 00000015

// ==== tests/cpu_core_tb.sv ====
`timescale 1ns/1ps

module cpu_core_tb;

    localparam int PAT_WORDS    = 256;
    localparam int WAIT_CYCLES  = 200;
    localparam int QUIET_CYCLES = 50;
    localparam int RESET_LIMIT  = 8000;

    logic           clk;
    logic           rst;
    logic           hold;
    logic           prog_we;
    logic [9:0]     prog_addr;
    cpu_pkg::word_t prog_data;
    logic           tohost_valid;
    cpu_pkg::word_t tohost_data;

    // image of the pattern file: count, program, count, expected values
    cpu_pkg::word_t pat [PAT_WORDS];
    int             prog_len;
    int             exp_len;
    int             exp_base;

    clock_gen clk0 (.hold(hold), .clk(clk), .rst(rst));

    cpu_core dut0 (
        .clk(clk),
        .rst(rst),
        .prog_we(prog_we),
        .prog_addr(prog_addr),
        .prog_data(prog_data),
        .tohost_valid(tohost_valid),
        .tohost_data(tohost_data)
    );

    bind cpu_core cpu_core_chk chk0 (
        .clk(clk),
        .rst(rst),
        .tohost_valid(tohost_valid),
        .pc(pc),
        .rs1_ex(ex.rs1),
        .rs2_ex(ex.rs2),
        .a_ex(a_ex),
        .b_ex(b_ex)
    );

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input cpu_pkg::word_t expected,
                              input cpu_pkg::word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s: expected %08h, actual %08h", name, expected, actual));
        end
    endtask

    function automatic bit parse_counts();
        prog_len = int'(pat[0]);
        exp_base = prog_len + 2;
        if (prog_len < 1 || prog_len > 1024 || exp_base >= PAT_WORDS) begin
            return 1'b0;
        end
        exp_len = int'(pat[prog_len + 1]);
        return exp_len > 0 && exp_base + exp_len <= PAT_WORDS;
    endfunction

    // one imem word per strobe while reset is held
    task automatic load_program();
        for (int i = 0; i < prog_len; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= 10'(i);
            prog_data <= pat[1 + i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
        hold    <= 1'b0;
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst && n < RESET_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (rst) begin
            abort_run("reset was never released");
        end
    endtask

    // outputs change on the rising edge, so look at them on the falling one
    task automatic wait_tohost(output cpu_pkg::word_t data);
        int n;
        bit seen;
        n = 0;
        seen = 1'b0;
        while (!seen && n < WAIT_CYCLES) begin
            @(negedge clk);
            seen = tohost_valid;
            n++;
        end
        if (seen) begin
            data = tohost_data;
        end else begin
            abort_run("no tohost write within timeout");
        end
    endtask

    task automatic check_results();
        cpu_pkg::word_t got;
        for (int i = 0; i < exp_len; i++) begin
            wait_tohost(got);
            check_word($sformatf("tohost write %0d", i), pat[exp_base + i], got);
        end
    endtask

    task automatic expect_quiet();
        int n;
        bit extra;
        n = 0;
        extra = 1'b0;
        while (!extra && n < QUIET_CYCLES) begin
            @(negedge clk);
            extra = tohost_valid;
            n++;
        end
        if (extra) begin
            abort_run($sformatf("unexpected tohost write of %08h after the last expected one",
                                tohost_data));
        end
    endtask

    initial begin
        hold      = 1'b1;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        $readmemh("tests/cpu_core_patterns.txt", pat);
        if (!parse_counts()) begin
            abort_run("pattern file holds no valid word counts");
        end else begin
            load_program();
            wait_reset_release();
            check_results();
            expect_quiet();
            $display("TEST PASS");
            $finish;
        end
    end

endmodule
